/* flist.f */
+incdir+tests
verilog/rs_pkg.sv
verilog/rs_dispatch.sv
verilog/reservation_station.sv
verilog/cdb_arbiter.sv
verilog/rs_subsystem_top.sv
tests/tb_rs_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the reservation station testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -Wno-fatal \
  --top-module tb_rs_subsystem \
  -f flist.f \
  -o tb_rs_subsystem

# A crash of the simulator stops the script here
./obj_dir/tb_rs_subsystem > "$LOG" 2>&1
cat "$LOG"

if grep -q "Some tests failed" "$LOG"; then
  echo "Simulation FAILED, see $LOG"
  exit 1
fi

echo "Simulation finished without failures"
exit 0

/* tests/tb_rs_vectors.svh */
`ifndef TB_RS_VECTORS_SVH
`define TB_RS_VECTORS_SVH

// Row modes
localparam int M_NORMAL = 0;
// Dispatch in the broadcast cycle of the src_a producer
localparam int M_SYNC   = 1;
// Hold res_ack off from this row on
localparam int M_HOLD   = 2;
// disp_ack must stay low until res_ack is released
localparam int M_STALL  = 3;
// Pulse flush once the row is inserted
localparam int M_FLUSH  = 4;

typedef struct {
  string     name;
  int        mode;
  bit        last;
  dispatch_t ins;
} row_t;

row_t rows[$];

function automatic src_t imm_src(input logic [DATA_W-1:0] v);
  src_t s;
  s.ready      = 1'b1;
  s.opnd.value = v;
  return s;
endfunction

function automatic src_t dep_src(input int tag);
  src_t s;
  s.ready             = 1'b0;
  s.opnd.tag_view.pad = '0;
  s.opnd.tag_view.tag = TAG_W'(tag);
  return s;
endfunction

task automatic add_row(input string name, input int mode, input bit last, input fu_t fu,
                       input fu_op_t op, input int tag, input src_t a, input src_t b);
  row_t r;
  r.name = name;
  r.mode = mode;
  r.last = last;
  r.ins  = '{fu: fu, op: op, dst_tag: TAG_W'(tag), src_a: a, src_b: b};
  rows.push_back(r);
endtask

// Opcode rules, OP_ADDR is base plus offset
function automatic logic [DATA_W-1:0] op_result(input fu_op_t op, input logic [DATA_W-1:0] a,
                                                input logic [DATA_W-1:0] b);
  case (op)
    OP_ADD:    return a + b;
    OP_SUB:    return a - b;
    OP_AND:    return a & b;
    OP_OR:     return a | b;
    OP_XOR:    return a ^ b;
    OP_PASS_A: return a;
    OP_ADDR:   return a + b;
    default:   return '0;
  endcase
endfunction

// Columns: name, mode, last row of group, lane, op, dst tag, src a, src b
task automatic load_table();
  add_row("indep_add", M_NORMAL, 0, FU_0, OP_ADD, 0, imm_src(32'h1234), imm_src(32'h4321));
  add_row("indep_sub", M_NORMAL, 0, FU_1, OP_SUB, 1, imm_src(32'h10), imm_src(32'h20));
  add_row("indep_or", M_NORMAL, 0, FU_0, OP_OR, 2, imm_src(32'hF0F0_0000),
          imm_src(32'h0000_0F0F));
  add_row("indep_pass", M_NORMAL, 0, FU_1, OP_PASS_A, 3, imm_src(32'hDEAD_BEEF), imm_src(1));
  add_row("indep_addr", M_NORMAL, 1, FU_0, OP_ADDR, 4, imm_src(32'h8000_0000), imm_src(32'h40));
  for (int i = 0; i < 6; i++) begin
    add_row($sformatf("rand_%0d", i), M_NORMAL, i == 5, fu_t'(i % 2), fu_op_t'(i % 6),
            i, imm_src($urandom), imm_src($urandom));
  end
  // Dependent chain alternating lanes
  add_row("chain_head", M_NORMAL, 0, FU_0, OP_ADD, 5, imm_src(3), imm_src(4));
  add_row("chain_cdb_same_cycle", M_SYNC, 0, FU_1, OP_SUB, 6, dep_src(5), imm_src(1));
  add_row("chain_xor", M_NORMAL, 0, FU_0, OP_XOR, 7, dep_src(6), dep_src(5));
  add_row("chain_and", M_NORMAL, 0, FU_1, OP_AND, 8, dep_src(7), imm_src(32'hFF));
  add_row("chain_addr", M_NORMAL, 1, FU_0, OP_ADDR, 9, dep_src(8), imm_src(32'h100));
  // One result plus four entries fill lane 0 with RS_SIZE of 4
  add_row("bp_hold", M_HOLD, 0, FU_0, OP_ADD, 0, imm_src(1), imm_src(2));
  add_row("bp_fill1", M_NORMAL, 0, FU_0, OP_SUB, 1, imm_src(100), imm_src(1));
  add_row("bp_fill2", M_NORMAL, 0, FU_0, OP_XOR, 2, imm_src(32'hAAAA_AAAA),
          imm_src(32'h5555_5555));
  add_row("bp_fill3", M_NORMAL, 0, FU_0, OP_OR, 3, imm_src(8), imm_src(1));
  add_row("bp_fill4", M_NORMAL, 0, FU_0, OP_AND, 4, imm_src(32'hFFFF), imm_src(32'h0F0F));
  add_row("bp_stall", M_STALL, 1, FU_0, OP_PASS_A, 5, imm_src(77), imm_src(0));
  // Tags 10 to 12 are flushed
  add_row("fl_hold", M_HOLD, 0, FU_0, OP_ADD, 10, imm_src(5), imm_src(6));
  add_row("fl_lane1", M_NORMAL, 0, FU_1, OP_XOR, 11, imm_src(3), imm_src(5));
  add_row("fl_flush", M_FLUSH, 0, FU_0, OP_SUB, 12, dep_src(10), imm_src(2));
  add_row("fl_after", M_NORMAL, 0, FU_1, OP_ADD, 13, imm_src(40), imm_src(2));
  add_row("fl_after_dep", M_NORMAL, 1, FU_0, OP_ADDR, 14, dep_src(13), imm_src(32'h20));
endtask

`endif

/* tests/tb_rs_subsystem.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_rs_subsystem
  import rs_pkg::*;
();

  localparam int RS_SIZE   = 4;
  localparam int NUM_FU    = 2;
  localparam int NUM_TAGS  = 2 ** TAG_W;
  localparam int STALL_CYC = 8;
  localparam int ROW_CYC   = 64;

  logic      in_clk = 1'b0;
  logic      in_rst_n;
  logic      flush;
  logic      disp_req;
  dispatch_t disp_bus;
  logic      disp_ack;
  logic      res_req;
  cdb_t      res_bus;
  logic      res_ack;

  // Scoreboard by tag
  logic [DATA_W-1:0] exp_value [NUM_TAGS];
  logic              exp_valid [NUM_TAGS];
  int                got       [NUM_TAGS];
  string             tag_name  [NUM_TAGS];

  logic hold_ack;
  int   errors;
  int   cycles;
  int   cycle_limit;

  `include "tb_rs_vectors.svh"

  rs_subsystem_top #(
    .RS_SIZE(RS_SIZE),
    .NUM_FU (NUM_FU)
  ) rs_subsystem_top_inst (
    .in_clk  (in_clk),
    .in_rst_n(in_rst_n),
    .flush   (flush),
    .disp_req(disp_req),
    .disp_bus(disp_bus),
    .disp_ack(disp_ack),
    .res_req (res_req),
    .res_bus (res_bus),
    .res_ack (res_ack)
  );

  always #4 in_clk = ~in_clk;

  always @(posedge in_clk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("Timeout after %0d cycles, %0d errors so far", cycles, errors);
      $display("Some tests failed");
      $finish;
    end
  end

  task automatic check_result(input cdb_t r);
    if (r.valid !== 1'b1) begin
      errors++;
      $display("ERR %s: res_bus valid expected 1, actual %b (tag %0d)", tag_name[r.tag],
               r.valid, r.tag);
    end
    if (!exp_valid[r.tag]) begin
      errors++;
      $display("Unexpected result for tag %0d, flushed or never dispatched", r.tag);
    end else if (got[r.tag] != 0) begin
      errors++;
      $display("Tag %0d produced a second result", r.tag);
    end else if (r.value !== exp_value[r.tag]) begin
      errors++;
      $display("ERR %s: expected %h, actual %h (tag %0d)", tag_name[r.tag],
               exp_value[r.tag], r.value, r.tag);
    end
    got[r.tag]++;
  endtask

  // Result side acks after a random delay unless held off
  initial begin : responder
    int unsigned delay;
    res_ack = 1'b0;
    forever begin
      @(negedge in_clk);
      if (res_req && !res_ack && !hold_ack) begin
        delay = $urandom % 6;
        repeat (delay) begin
          @(negedge in_clk);
        end
        check_result(res_bus);
        res_ack = 1'b1;
        do begin
          @(negedge in_clk);
        end while (res_req);
        res_ack = 1'b0;
      end
    end
  end

  task automatic clear_scoreboard();
    for (int t = 0; t < NUM_TAGS; t++) begin
      exp_valid[t] = 1'b0;
      got[t]       = 0;
      tag_name[t]  = "";
    end
  endtask

  function automatic logic [DATA_W-1:0] src_value(input src_t s);
    if (s.ready) begin
      return s.opnd.value;
    end
    return exp_value[s.opnd.tag_view.tag];
  endfunction

  // Producer already broadcast, so the ROB supplies the value
  function automatic src_t resolve(input src_t s);
    if (!s.ready && got[s.opnd.tag_view.tag] != 0) begin
      return imm_src(exp_value[s.opnd.tag_view.tag]);
    end
    return s;
  endfunction

  // Returns on the negedge right after res_req falls for this tag
  task automatic wait_broadcast(input logic [TAG_W-1:0] tag);
    logic prev;
    prev = res_req;
    forever begin
      @(negedge in_clk);
      if (prev && !res_req && res_bus.tag == tag) begin
        break;
      end
      prev = res_req;
    end
  endtask

  task automatic send(input dispatch_t ins, input bit stall);
    disp_bus = ins;
    disp_req = 1'b1;
    if (stall) begin
      repeat (STALL_CYC) begin
        @(negedge in_clk);
        if (disp_ack) begin
          errors++;
          $display("disp_ack rose for tag %0d while its lane was full", ins.dst_tag);
        end
      end
      hold_ack = 1'b0;
    end
    do begin
      @(negedge in_clk);
    end while (!disp_ack);
    disp_req = 1'b0;
    do begin
      @(negedge in_clk);
    end while (disp_ack);
  endtask

  task automatic flush_all();
    flush = 1'b1;
    @(negedge in_clk);
    flush = 1'b0;
    // Outstanding tags must never show up now
    for (int t = 0; t < NUM_TAGS; t++) begin
      if (exp_valid[t] && got[t] == 0) begin
        exp_valid[t] = 1'b0;
      end
    end
    hold_ack = 1'b0;
  endtask

  task automatic drain();
    bit done;
    do begin
      @(negedge in_clk);
      done = 1'b1;
      for (int t = 0; t < NUM_TAGS; t++) begin
        if (exp_valid[t] && got[t] == 0) begin
          done = 1'b0;
        end
      end
    end while (!done);
    // Time for a stray second result to show up
    repeat (8) begin
      @(negedge in_clk);
    end
    clear_scoreboard();
  endtask

  task automatic run_row(input row_t r);
    dispatch_t ins;
    ins = r.ins;
    if (r.mode == M_HOLD) begin
      hold_ack = 1'b1;
    end
    if (r.mode == M_SYNC) begin
      wait_broadcast(ins.src_a.opnd.tag_view.tag);
    end else begin
      ins.src_a = resolve(ins.src_a);
      ins.src_b = resolve(ins.src_b);
    end
    exp_value[ins.dst_tag] = op_result(ins.op, src_value(ins.src_a), src_value(ins.src_b));
    exp_valid[ins.dst_tag] = 1'b1;
    got[ins.dst_tag]       = 0;
    tag_name[ins.dst_tag]  = r.name;
    send(ins, r.mode == M_STALL);
    if (r.mode == M_FLUSH) begin
      flush_all();
    end
    if (r.last) begin
      drain();
    end
  endtask

  initial begin
    void'($urandom(15672));
    in_rst_n = 1'b0;
    flush    = 1'b0;
    disp_req = 1'b0;
    disp_bus = '0;
    hold_ack = 1'b0;
    errors   = 0;
    cycles   = 0;
    clear_scoreboard();
    load_table();
    cycle_limit = ROW_CYC * rows.size();
    repeat (3) begin
      @(posedge in_clk);
    end
    @(negedge in_clk);
    in_rst_n = 1'b1;
    @(negedge in_clk);
    foreach (rows[i]) begin
      run_row(rows[i]);
    end
    $display("Ran %0d rows, %0d errors", rows.size(), errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/rs_subsystem_top.sv */
`timescale 1ns/100ps
`default_nettype none

module rs_subsystem_top
  import rs_pkg::*;
#(
  parameter int RS_SIZE = 4,
  parameter int NUM_FU  = 2
) (
  input  logic      in_clk,
  input  logic      in_rst_n,
  input  logic      flush,
  input  logic      disp_req,
  input  dispatch_t disp_bus,
  output logic      disp_ack,
  output logic      res_req,
  output cdb_t      res_bus,
  input  logic      res_ack
);

  logic [NUM_FU-1:0] lane_full;
  logic [NUM_FU-1:0] lane_insert;
  logic [NUM_FU-1:0] lane_taken;
  dispatch_t         insert_bus;
  cdb_t [NUM_FU-1:0] lane_result;
  cdb_t              cdb;

  rs_dispatch #(
    .NUM_FU(NUM_FU)
  ) rs_dispatch_inst (
    .in_clk     (in_clk),
    .in_rst_n   (in_rst_n),
    .disp_req   (disp_req),
    .disp_bus   (disp_bus),
    .disp_ack   (disp_ack),
    .lane_full  (lane_full),
    .flush      (flush),
    .lane_insert(lane_insert),
    .insert_bus (insert_bus)
  );

  // One lane per functional unit, all sharing the broadcast bus
  for (genvar i = 0; i < NUM_FU; i++) begin : g_lane
    reservation_station #(
      .RS_SIZE(RS_SIZE)
    ) reservation_station_inst (
      .in_clk    (in_clk),
      .in_rst_n  (in_rst_n),
      .flush     (flush),
      .insert    (lane_insert[i]),
      .insert_bus(insert_bus),
      .cdb       (cdb),
      .full      (lane_full[i]),
      .result    (lane_result[i]),
      .taken     (lane_taken[i])
    );
  end

  cdb_arbiter #(
    .NUM_FU(NUM_FU)
  ) cdb_arbiter_inst (
    .in_clk     (in_clk),
    .in_rst_n   (in_rst_n),
    .flush      (flush),
    .lane_result(lane_result),
    .lane_taken (lane_taken),
    .cdb        (cdb),
    .res_req    (res_req),
    .res_bus    (res_bus),
    .res_ack    (res_ack)
  );

endmodule

`default_nettype wire

/* verilog/cdb_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module cdb_arbiter
  import rs_pkg::*;
#(
  parameter int NUM_FU = 2
) (
  input  logic                  in_clk,
  input  logic                  in_rst_n,
  input  logic                  flush,
  input  cdb_t [NUM_FU-1:0]     lane_result,
  output logic [NUM_FU-1:0]     lane_taken,
  output cdb_t                  cdb,
  output logic                  res_req,
  output cdb_t                  res_bus,
  input  logic                  res_ack
);

  localparam int LANE_W = (NUM_FU > 1) ? $clog2(NUM_FU) : 1;

  typedef enum logic [1:0] {
    A_IDLE,
    A_REQ,
    A_DONE
  } arb_state_t;

  arb_state_t        state;
  logic [LANE_W-1:0] rr_ptr;
  logic [LANE_W-1:0] pick;
  logic [LANE_W-1:0] owner;
  logic              any_pending;
  logic              grab;
  logic              cdb_valid;
  logic [TAG_W-1:0]  hold_tag;
  logic [DATA_W-1:0] hold_value;

  // Round robin, first pending lane at or after rr_ptr
  always_comb begin
    int idx;
    pick        = rr_ptr;
    any_pending = 1'b0;
    for (int off = NUM_FU - 1; off >= 0; off--) begin
      idx = (int'(rr_ptr) + off) % NUM_FU;
      if (lane_result[idx].valid) begin
        pick        = LANE_W'(idx);
        any_pending = 1'b1;
      end
    end
  end

  // New request only once the previous ack has gone low
  assign grab = (state == A_IDLE) && any_pending && !res_ack && !flush;

  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      state      <= A_IDLE;
      res_req    <= 1'b0;
      cdb_valid  <= 1'b0;
      lane_taken <= '0;
      rr_ptr     <= '0;
      owner      <= '0;
    end else begin
      cdb_valid  <= 1'b0;
      lane_taken <= '0;
      case (state)
        A_IDLE: begin
          if (grab) begin
            owner   <= pick;
            rr_ptr  <= (int'(pick) == NUM_FU - 1) ? '0 : pick + 1'b1;
            res_req <= 1'b1;
            state   <= A_REQ;
          end
        end
        A_REQ: begin
          if (flush) begin
            // Unacknowledged result is dropped
            res_req <= 1'b0;
            state   <= A_IDLE;
          end else if (res_ack) begin
            res_req           <= 1'b0;
            cdb_valid         <= 1'b1;
            lane_taken[owner] <= 1'b1;
            state             <= A_DONE;
          end
        end
        A_DONE: begin
          if (!res_ack) begin
            state <= A_IDLE;
          end
        end
        default: begin
          state <= A_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge in_clk) begin
    if (grab) begin
      hold_tag   <= lane_result[pick].tag;
      hold_value <= lane_result[pick].value;
    end
  end

  assign cdb     = '{valid: cdb_valid, tag: hold_tag, value: hold_value};
  assign res_bus = '{valid: res_req, tag: hold_tag, value: hold_value};

endmodule

`default_nettype wire

/* verilog/reservation_station.sv */
`timescale 1ns/100ps
`default_nettype none

module reservation_station
  import rs_pkg::*;
#(
  parameter int RS_SIZE = 4
) (
  input  logic      in_clk,
  input  logic      in_rst_n,
  input  logic      flush,
  input  logic      insert,
  input  dispatch_t insert_bus,
  input  cdb_t      cdb,
  output logic      full,
  output cdb_t      result,
  input  logic      taken
);

  localparam int IDX_W = (RS_SIZE > 1) ? $clog2(RS_SIZE) : 1;

  typedef struct packed {
    fu_op_t           op;
    logic [TAG_W-1:0] dst_tag;
    src_t             src_a;
    src_t             src_b;
  } rs_entry_t;

  rs_entry_t         entries [RS_SIZE];
  logic [RS_SIZE-1:0] ent_valid;
  logic [RS_SIZE-1:0] ent_ready;
  logic [IDX_W-1:0]  free_idx;
  logic [IDX_W-1:0]  issue_idx;
  logic              any_free;
  logic              any_ready;
  logic              do_issue;
  rs_entry_t         sel;
  logic [DATA_W-1:0] alu_out;
  logic              res_valid;
  logic [TAG_W-1:0]  res_tag;
  logic [DATA_W-1:0] res_value;

  // Capture a broadcast value when the waiting tag matches
  function automatic src_t wake(input src_t src, input cdb_t bus);
    src_t woken;
    woken = src;
    if (!src.ready && bus.valid && (src.opnd.tag_view.tag == bus.tag)) begin
      woken.ready      = 1'b1;
      woken.opnd.value = bus.value;
    end
    return woken;
  endfunction

  always_comb begin
    for (int i = 0; i < RS_SIZE; i++) begin
      ent_ready[i] = ent_valid[i] && entries[i].src_a.ready && entries[i].src_b.ready;
    end
  end

  // Lowest index wins in both encoders, so scan downward
  always_comb begin
    free_idx  = '0;
    any_free  = 1'b0;
    issue_idx = '0;
    any_ready = 1'b0;
    for (int i = RS_SIZE - 1; i >= 0; i--) begin
      if (!ent_valid[i]) begin
        free_idx = IDX_W'(i);
        any_free = 1'b1;
      end
      if (ent_ready[i]) begin
        issue_idx = IDX_W'(i);
        any_ready = 1'b1;
      end
    end
  end

  assign full = !any_free;

  // A pending result blocks issue
  assign do_issue = any_ready && !res_valid;

  assign sel = entries[issue_idx];

  // Execute stage
  always_comb begin
    case (sel.op)
      // OP_ADDR adds base and offset like load and store address updates
      OP_ADD, OP_ADDR: alu_out = sel.src_a.opnd.value + sel.src_b.opnd.value;
      OP_SUB:    alu_out = sel.src_a.opnd.value - sel.src_b.opnd.value;
      OP_AND:    alu_out = sel.src_a.opnd.value & sel.src_b.opnd.value;
      OP_OR:     alu_out = sel.src_a.opnd.value | sel.src_b.opnd.value;
      OP_XOR:    alu_out = sel.src_a.opnd.value ^ sel.src_b.opnd.value;
      OP_PASS_A: alu_out = sel.src_a.opnd.value;
      default:   alu_out = '0;
    endcase
  end

  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      ent_valid <= '0;
    end else if (flush) begin
      ent_valid <= '0;
    end else begin
      if (do_issue) begin
        ent_valid[issue_idx] <= 1'b0;
      end
      if (insert && any_free) begin
        ent_valid[free_idx] <= 1'b1;
      end
    end
  end

  // Entry payload takes wakeups first and a new insert on top
  always_ff @(posedge in_clk) begin
    for (int i = 0; i < RS_SIZE; i++) begin
      entries[i].src_a <= wake(entries[i].src_a, cdb);
      entries[i].src_b <= wake(entries[i].src_b, cdb);
    end
    if (insert && any_free) begin
      entries[free_idx].op      <= insert_bus.op;
      entries[free_idx].dst_tag <= insert_bus.dst_tag;
      entries[free_idx].src_a   <= wake(insert_bus.src_a, cdb);
      entries[free_idx].src_b   <= wake(insert_bus.src_b, cdb);
    end
  end

  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      res_valid <= 1'b0;
    end else if (flush) begin
      res_valid <= 1'b0;
    end else if (do_issue) begin
      res_valid <= 1'b1;
    end else if (taken) begin
      res_valid <= 1'b0;
    end
  end

  always_ff @(posedge in_clk) begin
    if (do_issue) begin
      res_tag   <= sel.dst_tag;
      res_value <= alu_out;
    end
  end

  assign result = '{valid: res_valid, tag: res_tag, value: res_value};

endmodule

`default_nettype wire

/* verilog/rs_dispatch.sv */
`timescale 1ns/100ps
`default_nettype none

module rs_dispatch
  import rs_pkg::*;
#(
  parameter int NUM_FU = 2
) (
  input  logic              in_clk,
  input  logic              in_rst_n,
  input  logic              disp_req,
  input  dispatch_t         disp_bus,
  output logic              disp_ack,
  input  logic [NUM_FU-1:0] lane_full,
  input  logic              flush,
  output logic [NUM_FU-1:0] lane_insert,
  output dispatch_t         insert_bus
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_INSERTED,
    S_WAIT_LOW
  } disp_state_t;

  disp_state_t       state;
  logic [NUM_FU-1:0] target;
  logic              target_ready;
  logic              do_insert;

  // One-hot decode of the unit field
  always_comb begin
    for (int i = 0; i < NUM_FU; i++) begin
      target[i] = (int'(disp_bus.fu) == i);
    end
  end

  // Only the addressed lane's full bit matters
  assign target_ready = |(target & ~lane_full);

  // Single insert per handshake, only taken from idle
  assign do_insert = (state == S_IDLE) && disp_req && target_ready && !flush;

  assign lane_insert = do_insert ? target : '0;
  assign insert_bus  = disp_bus;

  // Ack stays high from the insert edge until req has been seen low
  assign disp_ack = (state != S_IDLE);

  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE: begin
          if (do_insert) begin
            state <= S_INSERTED;
          end
        end
        S_INSERTED: begin
          state <= disp_req ? S_WAIT_LOW : S_IDLE;
        end
        S_WAIT_LOW: begin
          if (!disp_req) begin
            state <= S_IDLE;
          end
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/rs_pkg.sv */
`default_nettype none

package rs_pkg;

  // Operand and tag widths
  localparam int DATA_W = 32;
  localparam int TAG_W  = 4;

  // Target lane of an instruction, up to four lanes
  typedef enum logic [1:0] {
    FU_0,
    FU_1,
    FU_2,
    FU_3
  } fu_t;

  // Execute stage operations
  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_PASS_A,
    OP_ADDR
  } fu_op_t;

  // Tag view of an operand word, tag in the low bits
  typedef struct packed {
    logic [DATA_W-TAG_W-1:0] pad;
    logic [TAG_W-1:0]        tag;
  } operand_tag_t;

  // Operand word is either a value or the tag of its producer
  typedef union packed {
    logic [DATA_W-1:0] value;
    operand_tag_t      tag_view;
  } operand_u;

  // ready set means opnd holds a value, otherwise a tag
  typedef struct packed {
    logic     ready;
    operand_u opnd;
  } src_t;

  // Renamed instruction from the ROB
  typedef struct packed {
    fu_t              fu;
    fu_op_t           op;
    logic [TAG_W-1:0] dst_tag;
    src_t             src_a;
    src_t             src_b;
  } dispatch_t;

  // Broadcast bus and lane result record
  typedef struct packed {
    logic              valid;
    logic [TAG_W-1:0]  tag;
    logic [DATA_W-1:0] value;
  } cdb_t;

endpackage

`default_nettype wire
